/* data_path.sv */
`timescale 1ns/100ps
`default_nettype none

module data_path (
    input  wire logic               update_DR,
    input  wire logic               rst,
    input  wire jtag_pkg::dr_sel_t  dr_sel,
    input  wire logic               capture_dr,
    input  wire logic               shift_dr,
    input  wire logic               update_dr_strobe,
    input  wire logic               tdi,
    output logic                    dr_tdo,
    output jtag_pkg::mem_addr_t     start_addr,
    output jtag_pkg::mem_addr_t     end_addr,
    output logic                    mem_write,
    output jtag_pkg::mem_addr_t     mem_addr,
    output jtag_pkg::mem_data_t     mem_wdata
);
    import jtag_pkg::*;

    logic        en_bypass, en_idcode, en_addr, en_dload;
    logic        tdo_bypass, tdo_idcode, tdo_addr, tdo_dload;
    addr_range_t addr_q;  // Held start and end address
    dload_t      dload_q; // Held write address and data

    // Only the selected register captures, shifts or updates
    assign en_bypass = (dr_sel == BYPASS);
    assign en_idcode = (dr_sel == IDCODE);
    assign en_addr   = (dr_sel == ADDR);
    assign en_dload  = (dr_sel == DLOAD);

    ////////////////////////////////////////////////////////////
    // Data registers
    ////////////////////////////////////////////////////////////
    scan_register #(.payload_t(logic), .CAPTURE_ONLY(1'b1)) u_bypass (
        .update_DR(update_DR), .rst(rst), .enable(en_bypass),
        .capture(capture_dr), .shift(shift_dr), .update(update_dr_strobe),
        .tdi(tdi), .capture_value(1'b0), .reset_value(1'b0), // Leading 0 on tdo
        .serial_out(tdo_bypass), .parallel_out()
    );

    scan_register #(.payload_t(idcode_t), .CAPTURE_ONLY(1'b1)) u_idcode (
        .update_DR(update_DR), .rst(rst), .enable(en_idcode),
        .capture(capture_dr), .shift(shift_dr), .update(update_dr_strobe),
        .tdi(1'b1),            // Ones fill in behind the code
        .capture_value(IDCODE_VALUE), .reset_value(IDCODE_VALUE),
        .serial_out(tdo_idcode), .parallel_out()
    );

    scan_register #(.payload_t(addr_range_t), .CAPTURE_ONLY(1'b0)) u_addr (
        .update_DR(update_DR), .rst(rst), .enable(en_addr),
        .capture(capture_dr), .shift(shift_dr), .update(update_dr_strobe),
        .tdi(tdi), .capture_value(addr_q), // Reads back the held range
        .reset_value('0),
        .serial_out(tdo_addr), .parallel_out(addr_q)
    );

    scan_register #(.payload_t(dload_t), .CAPTURE_ONLY(1'b0)) u_dload (
        .update_DR(update_DR), .rst(rst), .enable(en_dload),
        .capture(capture_dr), .shift(shift_dr), .update(update_dr_strobe),
        .tdi(tdi), .capture_value('0), .reset_value('0),
        .serial_out(tdo_dload), .parallel_out(dload_q)
    );

    always_comb begin
        case (dr_sel)
            IDCODE:  dr_tdo = tdo_idcode;
            ADDR:    dr_tdo = tdo_addr;
            DLOAD:   dr_tdo = tdo_dload;
            default: dr_tdo = tdo_bypass;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Memory side
    ////////////////////////////////////////////////////////////
    assign start_addr = addr_q[2*MEM_ADDR_WIDTH-1:MEM_ADDR_WIDTH];
    assign end_addr   = addr_q[MEM_ADDR_WIDTH-1:0];
    assign mem_addr   = dload_q[MEM_ADDR_WIDTH+MEM_DATA_WIDTH-1:MEM_DATA_WIDTH];
    assign mem_wdata  = dload_q[MEM_DATA_WIDTH-1:0]; // Valid while mem_write is high

    // One pulse per DATALOAD update, same edge as the update stage
    always_ff @(posedge update_DR) begin
        if (rst) begin
            mem_write <= 1'b0;
        end else begin
            mem_write <= update_dr_strobe && (dr_sel == DLOAD);
        end
    end

    // Write pulse lasts a single cycle
    a_write_one_cycle : assert property (
        @(posedge update_DR) disable iff (rst)
        mem_write |=> !mem_write
    );

endmodule

`default_nettype wire

/* instruction_path.sv */
`timescale 1ns/100ps
`default_nettype none

module instruction_path (
    input  wire logic         update_DR,
    input  wire logic         rst,        // Held high in Test-Logic-Reset too
    input  wire logic         capture_ir,
    input  wire logic         shift_ir,
    input  wire logic         update_ir,
    input  wire logic         tdi,
    output logic              ir_tdo,
    output jtag_pkg::dr_sel_t dr_sel
);
    import jtag_pkg::*;

    instr_t instr; // Instruction in effect

    // IR is always in the chain when the IR strobes fire
    scan_register #(
        .payload_t    (instr_t),
        .CAPTURE_ONLY (1'b0)
    ) u_ir (
        .update_DR     (update_DR),
        .rst           (rst),
        .enable        (1'b1),
        .capture       (capture_ir),
        .shift         (shift_ir),
        .update        (update_ir),
        .tdi           (tdi),
        .capture_value (IR_CAPTURE),
        .reset_value   (INSTR_IDCODE), // IDCODE after reset
        .serial_out    (ir_tdo),
        .parallel_out  (instr)
    );

    ////////////////////////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (instr)
            INSTR_IDCODE:   dr_sel = IDCODE;
            INSTR_ADDRLOAD: dr_sel = ADDR;
            INSTR_DATALOAD: dr_sel = DLOAD;
            default:        dr_sel = BYPASS; // INSTR_BYPASS and every unknown code
        endcase
    end

endmodule

`default_nettype wire

/* jtag_debug_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module jtag_debug_tb;
    import jtag_pkg::*;

    ////////////////////////////////////////////////////////////
    // Run length
    ////////////////////////////////////////////////////////////
    localparam int NUM_SCANS       = 55;  // IR and DR scans over all sections
    localparam int MAX_SCAN_CYCLES = 64;  // 32 shifts, overhead, two pause detours
    localparam int WALK_ROUNDS     = 8;
    localparam int WALK_STEPS      = 20;
    localparam int PLANNED_CYCLES  = NUM_SCANS * MAX_SCAN_CYCLES
                                   + WALK_ROUNDS * (WALK_STEPS + 6) + 16;
    localparam int CYCLE_LIMIT     = 2 * PLANNED_CYCLES;

    localparam logic [31:0] EXP_IDCODE  = 32'hDEAD104D;
    localparam logic [3:0]  EXP_IR_CAPT = 4'b0001;   // Low bits 01
    localparam logic [3:0]  CODE_IDCODE = 4'b0100;

    // Data register chosen by the model's instruction
    localparam logic [1:0] SEL_BYPASS = 2'd0;
    localparam logic [1:0] SEL_IDCODE = 2'd1;
    localparam logic [1:0] SEL_ADDR   = 2'd2;
    localparam logic [1:0] SEL_DLOAD  = 2'd3;

    logic       update_DR, rst, tms, tdi;
    logic       tdo, tdo_en, mem_write, mem_reset;
    logic [7:0] start_addr, end_addr, mem_addr, mem_wdata;

    // Model of the TAP and its registers
    tap_state_t  m_state;
    logic [3:0]  m_ir_shift, m_instr;
    logic        m_bypass;
    logic [31:0] m_id_shift;
    logic [15:0] m_addr_shift, m_addr_held;
    logic [15:0] m_dl_shift, m_dl_held;
    logic        m_write;        // Expected mem_write this cycle
    logic        last_tdo;       // tdo seen in the last step
    int          cycle_count = 0;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(8)) u_clock_gen (
        .clk(update_DR), .rst(rst)
    );

    jtag_debug_top u_jtag_debug_top (
        .update_DR(update_DR), .rst(rst), .tms(tms), .tdi(tdi),
        .tdo(tdo), .tdo_en(tdo_en), .start_addr(start_addr), .end_addr(end_addr),
        .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_reset(mem_reset)
    );

    ////////////////////////////////////////////////////////////
    // Model
    ////////////////////////////////////////////////////////////
    function automatic tap_state_t tap_next(input tap_state_t s, input logic t);
        case (s)
            TAP_RESET:      return t ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       return t ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  return t ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: return t ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   return t ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   return t ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   return t ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   return t ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  return t ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  return t ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: return t ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   return t ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   return t ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   return t ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   return t ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  return t ? TAP_SELECT_DR : TAP_IDLE;
            default:        return TAP_RESET;
        endcase
    endfunction

    function automatic logic [1:0] select_of(input logic [3:0] code);
        case (code)
            4'b0100: return SEL_IDCODE;
            4'b0111: return SEL_ADDR;
            4'b0110: return SEL_DLOAD;
            default: return SEL_BYPASS;          // All other codes
        endcase
    endfunction

    function automatic logic expected_tdo();
        if (m_state == TAP_SHIFT_IR) begin
            return m_ir_shift[0];
        end
        case (select_of(m_instr))
            SEL_IDCODE: return m_id_shift[0];
            SEL_ADDR:   return m_addr_shift[0];
            SEL_DLOAD:  return m_dl_shift[0];
            default:    return m_bypass;
        endcase
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $urandom;
        return r[0];
    endfunction

    // Advance the model across one rising edge
    task automatic model_edge(input logic t, input logic d);
        logic [1:0] sel;
        sel = select_of(m_instr);
        m_write = (m_state == TAP_UPDATE_DR) && (sel == SEL_DLOAD);
        case (m_state)
            TAP_RESET: begin
                m_ir_shift = CODE_IDCODE;
                m_instr    = CODE_IDCODE;      // Instruction back to IDCODE
            end
            TAP_CAPTURE_IR: m_ir_shift = EXP_IR_CAPT;
            TAP_SHIFT_IR:   m_ir_shift = {d, m_ir_shift[3:1]};
            TAP_UPDATE_IR:  m_instr    = m_ir_shift;
            TAP_CAPTURE_DR: begin
                case (sel)
                    SEL_IDCODE: m_id_shift   = EXP_IDCODE;
                    SEL_ADDR:   m_addr_shift = m_addr_held; // Reads back held range
                    SEL_DLOAD:  m_dl_shift   = 16'h0000;
                    default:    m_bypass     = 1'b0;
                endcase
            end
            TAP_SHIFT_DR: begin
                case (sel)
                    SEL_IDCODE: m_id_shift   = {1'b1, m_id_shift[31:1]}; // Ones fill in
                    SEL_ADDR:   m_addr_shift = {d, m_addr_shift[15:1]};
                    SEL_DLOAD:  m_dl_shift   = {d, m_dl_shift[15:1]};
                    default:    m_bypass     = d;
                endcase
            end
            TAP_UPDATE_DR: begin
                if (sel == SEL_ADDR) begin
                    m_addr_held = m_addr_shift;
                end
                if (sel == SEL_DLOAD) begin
                    m_dl_held = m_dl_shift;
                end
            end
            default: ;
        endcase
        m_state = tap_next(m_state, t);
    endtask

    ////////////////////////////////////////////////////////////
    // Checks and stimulus
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Called on a falling edge; outputs have settled since the last rising edge
    task automatic step(input logic t, input logic d);
        logic exp_en;
        exp_en = (m_state == TAP_SHIFT_IR) || (m_state == TAP_SHIFT_DR);
        check_value("mem_reset", 64'(m_state == TAP_RESET), 64'(mem_reset));
        check_value("tdo_en", 64'(exp_en), 64'(tdo_en));
        if (exp_en) begin
            check_value("tdo", 64'(expected_tdo()), 64'(tdo)); // Bit the next edge shifts
        end
        check_value("mem_write", 64'(m_write), 64'(mem_write));
        if (m_write) begin
            check_value("mem_addr", 64'(m_dl_held[15:8]), 64'(mem_addr));
            check_value("mem_wdata", 64'(m_dl_held[7:0]), 64'(mem_wdata));
        end
        check_value("start_addr", 64'(m_addr_held[15:8]), 64'(start_addr));
        check_value("end_addr", 64'(m_addr_held[7:0]), 64'(end_addr));
        last_tdo = tdo;
        tms      = t;
        tdi      = d;
        model_edge(t, d);
        @(negedge update_DR);
    endtask

    // From Run-Test/Idle back to Run-Test/Idle
    task automatic ir_scan(input logic [3:0] code);
        logic [3:0] out;
        int         i;
        step(1'b1, rand_bit());          // Select-DR
        step(1'b1, rand_bit());          // Select-IR
        step(1'b0, rand_bit());          // Capture-IR
        step(1'b0, rand_bit());          // Shift-IR
        for (i = 0; i < 4; i++) begin
            step(i == 3, code[i]);       // Last bit leaves for Exit1-IR
            out[i] = last_tdo;
        end
        step(1'b1, rand_bit());          // Update-IR
        step(1'b0, rand_bit());          // Idle, instruction now live
        check_value("ir_capture", 64'(EXP_IR_CAPT), 64'(out));
    endtask

    task automatic dr_scan(input logic [63:0] data, input int len, input bit detours,
                           output logic [63:0] out);
        int          i;
        int          n_detours;
        logic [31:0] r;
        out       = '0;
        n_detours = 0;
        step(1'b1, rand_bit());          // Select-DR
        step(1'b0, rand_bit());          // Capture-DR
        step(1'b0, rand_bit());          // Shift-DR
        for (i = 0; i < len; i++) begin
            r = $urandom;
            if (detours && n_detours < 2 && i < len - 1 && r[2:0] == 3'd0) begin
                step(1'b1, data[i]);     // Shift one bit, into Exit1-DR
                out[i] = last_tdo;
                step(1'b0, rand_bit());  // Pause-DR
                repeat (r[4:3]) begin
                    step(1'b0, rand_bit());
                end
                step(1'b1, rand_bit());  // Exit2-DR
                step(1'b0, rand_bit());  // Back to Shift-DR
                n_detours++;
            end else begin
                step(i == len - 1, data[i]);
                out[i] = last_tdo;
            end
        end
        step(1'b1, rand_bit());          // Update-DR
        step(1'b0, rand_bit());          // Idle
    endtask

    // Guard against a stuck sequence
    always @(posedge update_DR) begin
        if (!rst) begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped, test sequence did not finish in %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [63:0] out;
        logic [31:0] r;
        logic [31:0] base;
        logic [15:0] prev;
        logic [3:0]  code;
        int          k;
        tms = 1'b1;
        tdi = 1'b0;
        void'($urandom(10));
        @(negedge rst);
        m_state      = TAP_RESET;
        m_ir_shift   = CODE_IDCODE;
        m_instr      = CODE_IDCODE;
        m_bypass     = 1'b0;
        m_id_shift   = EXP_IDCODE;
        m_addr_shift = 16'h0000;
        m_addr_held  = 16'h0000;
        m_dl_shift   = 16'h0000;
        m_dl_held    = 16'h0000;
        m_write      = 1'b0;

        // IDCODE straight after reset
        step(1'b1, 1'b0);
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);                // Idle
        r = $urandom;
        dr_scan(64'(r), 32, 1'b0, out);
        check_value("idcode", 64'(EXP_IDCODE), 64'(out[31:0]));

        // Every code once, in scrambled order; unlisted ones give a 1-bit bypass
        base = $urandom;
        for (k = 0; k < 16; k++) begin
            code = 4'(k) ^ base[3:0];
            ir_scan(code);
            r = $urandom;
            dr_scan(64'(r[7:0]), 9, 1'b0, out);
            if (select_of(code) == SEL_BYPASS) begin
                check_value("bypass", 64'({r[7:0], 1'b0}), 64'(out[8:0])); // Leading 0
            end
        end

        // ADDRLOAD with read back of the previous range
        ir_scan(4'b0111);
        prev = m_addr_held;
        for (k = 0; k < 6; k++) begin
            r = $urandom;
            dr_scan(64'(r[15:0]), 16, 1'b1, out);
            check_value("start_addr", 64'(r[15:8]), 64'(start_addr));
            check_value("end_addr", 64'(r[7:0]), 64'(end_addr));
            check_value("addr_readback", 64'(prev), 64'(out[15:0]));
            prev = r[15:0];
        end

        // DATALOAD gives one write cycle per update
        ir_scan(4'b0110);
        for (k = 0; k < 6; k++) begin
            r = $urandom;
            dr_scan(64'(r[15:0]), 16, 1'b1, out);
            check_value("mem_write", 64'd1, 64'(mem_write));
            check_value("mem_addr", 64'(r[15:8]), 64'(mem_addr));
            check_value("mem_wdata", 64'(r[7:0]), 64'(mem_wdata));
            check_value("dload_capture", 64'd0, 64'(out[15:0]));
            step(1'b0, rand_bit());
            check_value("mem_write", 64'd0, 64'(mem_write)); // Only one cycle
        end

        // Random walks, then five TMS-high cycles to Test-Logic-Reset
        for (k = 0; k < WALK_ROUNDS; k++) begin
            repeat (WALK_STEPS) begin
                step(rand_bit(), rand_bit());
            end
            repeat (5) begin
                step(1'b1, rand_bit());
            end
            check_value("mem_reset", 64'd1, 64'(mem_reset));
            step(1'b0, rand_bit());
            r = $urandom;
            dr_scan(64'(r), 32, 1'b0, out);
            check_value("idcode", 64'(EXP_IDCODE), 64'(out[31:0]));
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* jtag_debug_top.sv */
`timescale 1ns/100ps
`default_nettype none

module jtag_debug_top (
    input  wire logic           update_DR,
    input  wire logic           rst,
    input  wire logic           tms,
    input  wire logic           tdi,
    output logic                tdo,
    output logic                tdo_en,
    output jtag_pkg::mem_addr_t start_addr,
    output jtag_pkg::mem_addr_t end_addr,
    output logic                mem_write,
    output jtag_pkg::mem_addr_t mem_addr,
    output jtag_pkg::mem_data_t mem_wdata,
    output logic                mem_reset
);
    import jtag_pkg::*;

    logic    capture_ir, shift_ir, update_ir;
    logic    capture_dr, shift_dr, update_dr_strobe;
    logic    ir_tdo, dr_tdo;
    dr_sel_t dr_sel;

    tap_controller u_tap_controller (
        .update_DR(update_DR), .rst(rst), .tms(tms),
        .capture_ir(capture_ir), .shift_ir(shift_ir), .update_ir(update_ir),
        .capture_dr(capture_dr), .shift_dr(shift_dr),
        .update_dr_strobe(update_dr_strobe), .mem_reset(mem_reset)
    );

    // Test-Logic-Reset puts IDCODE back
    instruction_path u_instruction_path (
        .update_DR(update_DR), .rst(mem_reset),
        .capture_ir(capture_ir), .shift_ir(shift_ir), .update_ir(update_ir),
        .tdi(tdi), .ir_tdo(ir_tdo), .dr_sel(dr_sel)
    );

    data_path u_data_path (
        .update_DR(update_DR), .rst(rst), .dr_sel(dr_sel),
        .capture_dr(capture_dr), .shift_dr(shift_dr),
        .update_dr_strobe(update_dr_strobe), .tdi(tdi), .dr_tdo(dr_tdo),
        .start_addr(start_addr), .end_addr(end_addr), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    tdo_select u_tdo_select (
        .shift_ir(shift_ir), .shift_dr(shift_dr),
        .ir_tdo(ir_tdo), .dr_tdo(dr_tdo),
        .tdo(tdo), .tdo_en(tdo_en)
    );

endmodule

`default_nettype wire

/* jtag_pkg.sv */
`default_nettype none

package jtag_pkg;

    ////////////////////////////////////////////////////////////
    // TAP controller states
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        TAP_RESET      = 4'b0000, // Test-Logic-Reset
        TAP_IDLE       = 4'b0001, // Run-Test/Idle
        TAP_SELECT_DR  = 4'b0010,
        TAP_CAPTURE_DR = 4'b0011,
        TAP_SHIFT_DR   = 4'b0100,
        TAP_EXIT1_DR   = 4'b0101,
        TAP_PAUSE_DR   = 4'b0110,
        TAP_EXIT2_DR   = 4'b0111,
        TAP_UPDATE_DR  = 4'b1000,
        TAP_SELECT_IR  = 4'b1001,
        TAP_CAPTURE_IR = 4'b1010,
        TAP_SHIFT_IR   = 4'b1011,
        TAP_EXIT1_IR   = 4'b1100,
        TAP_PAUSE_IR   = 4'b1101,
        TAP_EXIT2_IR   = 4'b1110,
        TAP_UPDATE_IR  = 4'b1111
    } tap_state_t;

    ////////////////////////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////////////////////////
    localparam int IR_WIDTH = 4;
    typedef logic [IR_WIDTH-1:0] instr_t;

    localparam instr_t INSTR_BYPASS   = 4'b1111;
    localparam instr_t INSTR_IDCODE   = 4'b0100;
    localparam instr_t INSTR_DATALOAD = 4'b0110; // Memory write of one byte
    localparam instr_t INSTR_ADDRLOAD = 4'b0111; // Start and end address
    localparam instr_t IR_CAPTURE     = 4'b0001; // Low bits read 01 on capture

    // Data register between tdi and tdo
    typedef enum logic [1:0] {
        BYPASS = 2'b00,
        IDCODE = 2'b01,
        ADDR   = 2'b10,
        DLOAD  = 2'b11
    } dr_sel_t;

    ////////////////////////////////////////////////////////////
    // Data register payloads
    ////////////////////////////////////////////////////////////
    localparam logic [31:0] IDCODE_VALUE = 32'hDEAD104D;
    typedef logic [31:0] idcode_t;

    localparam int MEM_ADDR_WIDTH = 8;
    localparam int MEM_DATA_WIDTH = 8;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [MEM_DATA_WIDTH-1:0] mem_data_t;

    typedef logic [2*MEM_ADDR_WIDTH-1:0] addr_range_t;                // Start high, end low
    typedef logic [MEM_ADDR_WIDTH+MEM_DATA_WIDTH-1:0] dload_t;        // Address high, data low

endpackage

`default_nettype wire

/* project.f */
jtag_pkg.sv
tap_controller.sv
scan_register.sv
instruction_path.sv
data_path.sv
tdo_select.sv
jtag_debug_top.sv
tb_clock_gen.sv
jtag_debug_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the JTAG testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module jtag_debug_tb \
    -Mdir obj_dir -f project.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed"
    exit 1
fi

./obj_dir/Vjtag_debug_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed" "$SIM_LOG"; then
    exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

/* scan_register.sv */
`timescale 1ns/100ps
`default_nettype none

module scan_register #(
    parameter type payload_t    = logic,
    parameter bit  CAPTURE_ONLY = 1'b0   // No update stage, for IDCODE and BYPASS
) (
    input  wire logic     update_DR,
    input  wire logic     rst,
    input  wire logic     enable,        // Register selected between tdi and tdo
    input  wire logic     capture,
    input  wire logic     shift,
    input  wire logic     update,
    input  wire logic     tdi,
    input  wire payload_t capture_value,
    input  wire payload_t reset_value,
    output logic          serial_out,
    output payload_t      parallel_out
);
    localparam int WIDTH = $bits(payload_t);

    payload_t         shift_q;   // Shift stage
    logic [WIDTH-1:0] shift_ext; // tdi on top, one step to the right

    // Works down to a single bit
    assign shift_ext  = WIDTH'({tdi, shift_q} >> 1);
    assign serial_out = 1'(shift_q); // LSB leaves first

    ////////////////////////////////////////////////////////////
    // Shift stage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge update_DR) begin
        if (rst) begin
            shift_q <= reset_value;
        end else if (enable && capture) begin
            shift_q <= capture_value;
        end else if (enable && shift) begin
            shift_q <= shift_ext;
        end
    end

    ////////////////////////////////////////////////////////////
    // Update stage
    ////////////////////////////////////////////////////////////
    if (CAPTURE_ONLY) begin : g_capture_only
        assign parallel_out = shift_q; // Nothing is held
    end else begin : g_update
        payload_t update_q;

        always_ff @(posedge update_DR) begin
            if (rst) begin
                update_q <= reset_value;
            end else if (enable && update) begin
                update_q <= shift_q; // Shifted value goes live
            end
        end

        assign parallel_out = update_q;
    end

endmodule

`default_nettype wire

/* tap_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module tap_controller (
    input  wire logic update_DR,
    input  wire logic rst,
    input  wire logic tms,
    output logic      capture_ir,
    output logic      shift_ir,
    output logic      update_ir,
    output logic      capture_dr,
    output logic      shift_dr,
    output logic      update_dr_strobe,
    output logic      mem_reset
);
    import jtag_pkg::*;

    tap_state_t state;
    tap_state_t state_next;

    ////////////////////////////////////////////////////////////
    // State register and TAP graph
    ////////////////////////////////////////////////////////////
    always_ff @(posedge update_DR) begin
        if (rst) begin
            state <= TAP_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            TAP_RESET:      state_next = tms ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       state_next = tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  state_next = tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: state_next = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   state_next = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   state_next = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   state_next = tms ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   state_next = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR; // Back to shifting
            TAP_UPDATE_DR:  state_next = tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  state_next = tms ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: state_next = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   state_next = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   state_next = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   state_next = tms ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   state_next = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  state_next = tms ? TAP_SELECT_DR : TAP_IDLE;
            default:        state_next = TAP_RESET;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Strobes decoded from the current state
    ////////////////////////////////////////////////////////////
    // Each one acts on the edge that leaves its state
    assign capture_ir       = (state == TAP_CAPTURE_IR);
    assign shift_ir         = (state == TAP_SHIFT_IR);   // Includes the edge into Exit1-IR
    assign update_ir        = (state == TAP_UPDATE_IR);
    assign capture_dr       = (state == TAP_CAPTURE_DR);
    assign shift_dr         = (state == TAP_SHIFT_DR);
    assign update_dr_strobe = (state == TAP_UPDATE_DR);
    assign mem_reset        = (state == TAP_RESET);      // Also clears the instruction

    // Five TMS-high edges reach Test-Logic-Reset from any state
    a_tms_reset : assert property (
        @(posedge update_DR) disable iff (rst)
        (tms && $past(tms) && $past(tms, 2) && $past(tms, 3) && $past(tms, 4))
            |=> (state == TAP_RESET)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,  // ns
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a falling edge like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tdo_select.sv */
`timescale 1ns/100ps
`default_nettype none

module tdo_select (
    input  wire logic shift_ir,
    input  wire logic shift_dr,
    input  wire logic ir_tdo,
    input  wire logic dr_tdo,
    output logic      tdo,
    output logic      tdo_en
);

    // Output driver on only while a chain is shifting
    assign tdo_en = shift_ir | shift_dr;

    // IR chain in Shift-IR, data chain otherwise
    assign tdo = shift_ir ? ir_tdo : dr_tdo;

    // No clock here, so checked as the levels settle
    always_comb begin
        if (tdo_en) begin
            a_tdo_known : assert (!$isunknown(tdo));
        end
    end

endmodule

`default_nettype wire
